// File: files.f
+incdir+include
rtl/vec_pkg.sv
rtl/vec_decoder.sv
rtl/vec_inst_buffer.sv
rtl/vec_convoy_ctrl.sv
rtl/vec_dispatch.sv
rtl/vec_issue_top.sv
tb/tb_vec_issue.sv

// File: rtl/vec_convoy_ctrl.sv
`timescale 1ns/1ps

module vec_convoy_ctrl
	import vec_pkg::*;
(
	input  logic              reset,                 // Clock
	input  logic              clk,                   // Async reset, active high
	input  logic              branch_taken_ex_mem,
	input  logic              freeze_vector_ops,
	input  logic              exe_stall,
	input  logic              exe_done,
	input  logic              pres_is_vec,           // IF/ID holds a vector word
	input  logic              prev_is_vec,           // ID/EX holds a vector word
	output logic              cap_en,
	output logic              cap_sel_prev,
	output logic              buf_clear,
	output logic              disp_en,
	output logic              disp_clear,
	output logic              v_stall,               // Hold PC and IF/ID
	output logic              freeze,                // Any freeze of the scalar pipe
	output logic              freeze_x,              // Scalar word broke the convoy
	output logic              sv_vv,                 // Convoy entered after a scalar
	output logic [slot_w-1:0] cap_slot,
	output logic [slot_w:0]   cap_count,             // Words held in the record
	output logic [1:0]        release_count
);

	convoy_state_e state;
	logic [4:0]    cyc_cnt;           // Window cycle counter, saturates
	logic [4:0]    fill_cnt;
	logic          freeze_v;          // Overflow freeze
	logic          br_d;              // Branch one stage later
	logic          frz_d;             // Freeze request one stage later
	logic          frz_vec;
	logic          cancel;
	logic          sel_is_vec;
	logic          in_window;
	logic          scalar_hit;
	logic          done_ok;
	logic [1:0]    release_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Decisions of the current cycle
	assign cancel       = branch_taken_ex_mem | br_d;
	assign frz_vec      = sv_vv ? frz_d : freeze_vector_ops;   // Match the capture stage
	assign cap_sel_prev = sv_vv;
	assign sel_is_vec   = cap_sel_prev ? prev_is_vec : pres_is_vec;
	assign fill_cnt     = sv_vv ? 5'(n_slots) : 5'(n_slots - 1);

	// Capture cycles of the window, stopped by a scalar word
	assign in_window  = (state == st_collect) && (cyc_cnt < fill_cnt) && !frz_vec
		&& !freeze_x && !cancel;
	assign cap_en     = in_window && sel_is_vec;
	assign scalar_hit = in_window && !sel_is_vec;
	assign cap_slot   = cap_count[slot_w-1:0];

	// Completion is taken only once the window has drained
	assign done_ok = (state == st_dispatch) && exe_done && !exe_stall
		&& (cyc_cnt >= 5'(drain_thd));

	assign disp_en     = (state == st_dispatch);
	assign disp_clear  = cancel | done_ok;
	assign buf_clear   = cancel | ((state == st_release) && (release_count == release_thd));
	assign release_nxt = (release_count == 2'(max_release - 1)) ? 2'd0 : release_count + 2'd1;
	assign freeze      = freeze_v | freeze_x;

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			br_d  <= 1'b0;
			frz_d <= 1'b0;
		end else begin
			br_d  <= branch_taken_ex_mem;
			frz_d <= freeze_vector_ops;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state         <= st_idle;
			v_stall       <= 1'b0;
			sv_vv         <= 1'b0;
			freeze_x      <= 1'b0;
			freeze_v      <= 1'b0;
			cyc_cnt       <= '0;
			cap_count     <= '0;
			release_count <= '0;
		end else if (cancel) begin
			// Branch taken, abandon the convoy
			state         <= st_idle;
			v_stall       <= 1'b0;
			freeze_x      <= 1'b0;
			freeze_v      <= 1'b0;
			cyc_cnt       <= '0;
			cap_count     <= '0;
			release_count <= '0;
		end else begin
			if ((state != st_idle) && !frz_vec && (cyc_cnt != '1))
				cyc_cnt <= cyc_cnt + 5'd1;
			if (cap_en)
				cap_count <= cap_count + 1'b1;
			if (scalar_hit)
				freeze_x <= 1'b1;
			if (cap_en && (cap_count == n_slots - 1))
				freeze_v <= 1'b1;          // Record full

			case (state)
				st_idle: begin
					if (pres_is_vec) begin
						state   <= st_collect;
						v_stall <= 1'b1;
						sv_vv   <= !prev_is_vec;
					end
				end
				st_collect: begin
					if (cyc_cnt >= fill_cnt)
						state <= st_dispatch;
				end
				st_dispatch: begin
					if (done_ok) begin
						state         <= st_release;
						release_count <= release_nxt;
					end
				end
				st_release: begin
					release_count <= release_nxt;
					if (release_count == release_thd - 2) begin
						freeze_x <= 1'b0;
						freeze_v <= 1'b0;
					end
					if (release_count == release_thd) begin
						state     <= st_idle;   // Let the scalar pipe go
						v_stall   <= 1'b0;
						cyc_cnt   <= '0;
						cap_count <= '0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Capture must stop before the record wraps
	a_cap_room: assert property (@(posedge reset) disable iff (clk)
		cap_en |-> (cap_count < n_slots));

	a_idle_no_stall: assert property (@(posedge reset) disable iff (clk)
		(state == st_idle) |-> !v_stall);

endmodule

// File: rtl/vec_decoder.sv
`timescale 1ns/1ps

module vec_decoder
	import vec_pkg::*;
(
	input  logic [xlen-1:0]      instr,       // Word from one pipeline stage
	output logic                 is_vec,
	output logic [reg_idx_w-1:0] vs1,
	output logic [reg_idx_w-1:0] vs2,
	output logic [reg_idx_w-1:0] vd,
	output logic [reg_idx_w-1:0] rs1_idx,
	output logic [reg_idx_w-1:0] rs2_idx,
	output logic [reg_idx_w-1:0] uimm5,
	output logic [3:0]           funct,
	output alu_src_e             alu_src,
	output logic                 dm_rd,
	output logic                 dm_wr,
	output logic                 reg_we,
	output logic                 mem_reg,     // Write back from memory
	output logic                 x_out,       // Result goes to a scalar
	output lsu_mode_e            lsu_mode
);

	vec_opcode_e opcode;
	logic [2:0]  funct3;
	logic        scalar_res;

	assign opcode = vec_opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	// OPMVV with funct6 010000 moves an element or count to x[rd]
	assign scalar_res = (funct3 == 3'b010) && (instr[31:26] == 6'b010000);

	always_comb begin
		// Non-vector word leaves everything at zero
		is_vec   = 1'b0;
		vs1      = '0;
		vs2      = '0;
		vd       = '0;
		rs1_idx  = '0;
		rs2_idx  = '0;
		uimm5    = '0;
		funct    = '0;
		alu_src  = src_vv;
		dm_rd    = 1'b0;
		dm_wr    = 1'b0;
		reg_we   = 1'b0;
		mem_reg  = 1'b0;
		x_out    = 1'b0;
		lsu_mode = lsu_unit;

		case (opcode)
			op_vec_load, op_vec_store: begin
				is_vec  = 1'b1;
				alu_src = src_vx;                   // Base address from rs1
				dm_rd   = (opcode == op_vec_load);
				dm_wr   = (opcode == op_vec_store);
				reg_we  = (opcode == op_vec_load);
				mem_reg = (opcode == op_vec_load);
				case (instr[27:26])                 // mop field
					2'b00:   lsu_mode = lsu_unit;
					2'b10:   lsu_mode = lsu_strided;
					default: lsu_mode = lsu_indexed;
				endcase
			end
			op_vec_arith: begin
				is_vec = 1'b1;
				funct  = instr[29:26];              // Low bits of funct6
				x_out  = scalar_res;
				reg_we = !scalar_res;               // No vd write for scalar results
				case (funct3)
					3'b011:                 alu_src = src_vi;   // OPIVI
					3'b100, 3'b101, 3'b110: alu_src = src_vx;   // OPIVX, OPFVF, OPMVX
					default:                alu_src = src_vv;
				endcase
			end
			default: ;
		endcase

		// Register fields share one layout over all three formats
		if (is_vec) begin
			vd      = instr[11:7];
			vs1     = instr[19:15];
			vs2     = instr[24:20];
			rs1_idx = instr[19:15];
			rs2_idx = instr[24:20];
			uimm5   = instr[19:15];
		end
	end

endmodule

// File: rtl/vec_dispatch.sv
`timescale 1ns/1ps

module vec_dispatch
	import vec_pkg::*;
(
	input  logic                 reset,        // Clock
	input  logic                 clk,          // Async reset, active high
	input  logic                 disp_en,
	input  logic                 disp_clear,
	input  logic                 exe_stall,
	input  logic [slot_w:0]      cap_count,
	input  logic [xlen-1:0]      rs1_data,     // Scalar operands for the current slot
	input  logic [xlen-1:0]      rs2_data,
	input  logic [reg_idx_w-1:0] rd_vs1, rd_vs2, rd_vd,
	input  logic [reg_idx_w-1:0] rd_rs1_idx, rd_rs2_idx, rd_uimm5,
	input  logic [3:0]           rd_funct,
	input  alu_src_e             rd_alu_src,
	input  logic                 rd_dm_rd, rd_dm_wr, rd_reg_we, rd_mem_reg, rd_x_out,
	input  lsu_mode_e            rd_lsu_mode,
	output logic [slot_w-1:0]    rd_slot,
	output logic                 i_clear,
	output logic                 i_start,
	output logic [slot_w-1:0]    i_id,
	output logic [reg_idx_w-1:0] i_vs1, i_vs2, i_vd,
	output logic [xlen-1:0]      i_rs1, i_rs2,
	output logic [reg_idx_w-1:0] i_uimm5,
	output logic [3:0]           i_funct,
	output alu_src_e             i_alu_src,
	output logic                 i_dm_rd, i_dm_wr, i_reg_we, i_mem_reg, i_x_out,
	output lsu_mode_e            i_lsu_mode,
	output logic [reg_idx_w-1:0] rs1_sel,      // To the scalar register file
	output logic [reg_idx_w-1:0] rs2_sel
);

	logic [slot_w:0] disp_cnt;   // Next slot to issue
	logic            issue;

	assign issue   = disp_en && !exe_stall && (disp_cnt < cap_count);
	assign rd_slot = disp_cnt[slot_w-1:0];
	assign rs1_sel = rd_rs1_idx;   // Register file answers within the cycle
	assign rs2_sel = rd_rs2_idx;

	////////////////////////////////////////////////////////////////////////////
	// Issue control
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			disp_cnt <= '0;
			i_start  <= 1'b0;
			i_clear  <= 1'b1;
			i_id     <= '0;
		end else if (disp_clear) begin
			disp_cnt <= '0;
			i_start  <= 1'b0;
			i_clear  <= 1'b1;          // Flush the execution unit
			i_id     <= '0;
		end else begin
			i_start <= issue;
			if (issue) begin
				i_clear  <= 1'b0;
				i_id     <= rd_slot;
				disp_cnt <= disp_cnt + 1'b1;
			end
		end
	end

	// Issue payload
	always_ff @(posedge reset) begin
		if (disp_clear) begin
			i_vs1      <= '0;
			i_vs2      <= '0;
			i_vd       <= '0;
			i_rs1      <= '0;
			i_rs2      <= '0;
			i_uimm5    <= '0;
			i_funct    <= '0;
			i_alu_src  <= src_vv;
			i_dm_rd    <= 1'b0;
			i_dm_wr    <= 1'b0;
			i_reg_we   <= 1'b0;
			i_mem_reg  <= 1'b0;
			i_x_out    <= 1'b0;
			i_lsu_mode <= lsu_unit;
		end else if (issue) begin
			i_vs1      <= rd_vs1;
			i_vs2      <= rd_vs2;
			i_vd       <= rd_vd;
			i_rs1      <= rs1_data;
			i_rs2      <= rs2_data;
			i_uimm5    <= rd_uimm5;
			i_funct    <= rd_funct;
			i_alu_src  <= rd_alu_src;
			i_dm_rd    <= rd_dm_rd;
			i_dm_wr    <= rd_dm_wr;
			i_reg_we   <= rd_reg_we;
			i_mem_reg  <= rd_mem_reg;
			i_x_out    <= rd_x_out;
			i_lsu_mode <= rd_lsu_mode;
		end
	end

	// A stalled unit must never see a start
	a_no_start_in_stall: assert property (@(posedge reset) disable iff (clk)
		i_start |-> $past(!exe_stall));

endmodule

// File: rtl/vec_inst_buffer.sv
`timescale 1ns/1ps

module vec_inst_buffer
	import vec_pkg::*;
(
	input  logic                 reset,          // Clock
	input  logic                 clk,            // Async reset, active high
	input  logic                 buf_clear,      // Drop the whole record
	input  logic                 cap_en,
	input  logic                 cap_sel_prev,   // Take the ID/EX decode
	input  logic [slot_w-1:0]    cap_slot,
	input  logic [slot_w-1:0]    rd_slot,
	// IF/ID decode
	input  logic [reg_idx_w-1:0] pres_vs1, pres_vs2, pres_vd,
	input  logic [reg_idx_w-1:0] pres_rs1_idx, pres_rs2_idx, pres_uimm5,
	input  logic [3:0]           pres_funct,
	input  alu_src_e             pres_alu_src,
	input  logic                 pres_dm_rd, pres_dm_wr, pres_reg_we, pres_mem_reg, pres_x_out,
	input  lsu_mode_e            pres_lsu_mode,
	// ID/EX decode
	input  logic [reg_idx_w-1:0] prev_vs1, prev_vs2, prev_vd,
	input  logic [reg_idx_w-1:0] prev_rs1_idx, prev_rs2_idx, prev_uimm5,
	input  logic [3:0]           prev_funct,
	input  alu_src_e             prev_alu_src,
	input  logic                 prev_dm_rd, prev_dm_wr, prev_reg_we, prev_mem_reg, prev_x_out,
	input  lsu_mode_e            prev_lsu_mode,
	// Slot at rd_slot
	output logic [reg_idx_w-1:0] rd_vs1, rd_vs2, rd_vd,
	output logic [reg_idx_w-1:0] rd_rs1_idx, rd_rs2_idx, rd_uimm5,
	output logic [3:0]           rd_funct,
	output alu_src_e             rd_alu_src,
	output logic                 rd_dm_rd, rd_dm_wr, rd_reg_we, rd_mem_reg, rd_x_out,
	output lsu_mode_e            rd_lsu_mode
);

	typedef struct packed {
		logic [reg_idx_w-1:0] vs1, vs2, vd, rs1_idx, rs2_idx, uimm5;
		logic [3:0]           funct;
		alu_src_e             alu_src;
		logic                 dm_rd, dm_wr, reg_we, mem_reg, x_out;
		lsu_mode_e            lsu_mode;
	} slot_rec_t;

	slot_rec_t            rec_mem [n_slots];   // Instruction record
	slot_rec_t            pres_rec, prev_rec, cap_rec, rd_rec;
	logic [n_slots-1:0]   slot_vld;            // Slot holds a word of this convoy

	assign pres_rec = '{pres_vs1, pres_vs2, pres_vd, pres_rs1_idx, pres_rs2_idx, pres_uimm5,
		pres_funct, pres_alu_src, pres_dm_rd, pres_dm_wr, pres_reg_we, pres_mem_reg,
		pres_x_out, pres_lsu_mode};
	assign prev_rec = '{prev_vs1, prev_vs2, prev_vd, prev_rs1_idx, prev_rs2_idx, prev_uimm5,
		prev_funct, prev_alu_src, prev_dm_rd, prev_dm_wr, prev_reg_we, prev_mem_reg,
		prev_x_out, prev_lsu_mode};
	assign cap_rec = cap_sel_prev ? prev_rec : pres_rec;   // Scalar-vector entry uses ID/EX

	////////////////////////////////////////////////////////////////////////////
	// Capture
	always_ff @(posedge reset) begin
		if (cap_en)
			rec_mem[cap_slot] <= cap_rec;
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk)
			slot_vld <= '0;
		else if (buf_clear)
			slot_vld <= '0;                // Convoy over or cancelled
		else if (cap_en)
			slot_vld[cap_slot] <= 1'b1;
	end

	// Read port, empty slots read as zero
	assign rd_rec       = slot_vld[rd_slot] ? rec_mem[rd_slot] : '0;
	assign rd_vs1       = rd_rec.vs1;
	assign rd_vs2       = rd_rec.vs2;
	assign rd_vd        = rd_rec.vd;
	assign rd_rs1_idx   = rd_rec.rs1_idx;
	assign rd_rs2_idx   = rd_rec.rs2_idx;
	assign rd_uimm5     = rd_rec.uimm5;
	assign rd_funct     = rd_rec.funct;
	assign rd_alu_src   = rd_rec.alu_src;
	assign rd_dm_rd     = rd_rec.dm_rd;
	assign rd_dm_wr     = rd_rec.dm_wr;
	assign rd_reg_we    = rd_rec.reg_we;
	assign rd_mem_reg   = rd_rec.mem_reg;
	assign rd_x_out     = rd_rec.x_out;
	assign rd_lsu_mode  = rd_rec.lsu_mode;

	// A clear and a capture in one cycle would leave a stale valid slot
	a_no_cap_on_clear: assert property (@(posedge reset) disable iff (clk)
		!(cap_en && buf_clear));

endmodule

// File: rtl/vec_issue_top.sv
`timescale 1ns/1ps

module vec_issue_top
	import vec_pkg::*;
(
	input  logic                 reset,                 // Clock
	input  logic                 clk,                   // Async reset, active high
	input  logic                 branch_taken_ex_mem,
	input  logic                 freeze_vector_ops,
	input  logic                 exe_stall,             // From the execution unit
	input  logic                 exe_done,
	input  logic [xlen-1:0]      inst_if_id,
	input  logic [xlen-1:0]      inst_id_ex,
	input  logic [xlen-1:0]      rs1_data,
	input  logic [xlen-1:0]      rs2_data,
	output logic                 sv_vv,
	output logic                 v_stall,
	output logic                 freeze,
	output logic                 freeze_x,
	output logic [1:0]           release_count,
	output logic [reg_idx_w-1:0] rs1_sel,
	output logic [reg_idx_w-1:0] rs2_sel,
	// Toward the execution unit
	output logic                 i_clear,
	output logic                 i_start,
	output logic [slot_w-1:0]    i_id,
	output logic [reg_idx_w-1:0] i_vs1, i_vs2, i_vd,
	output logic [xlen-1:0]      i_rs1, i_rs2,
	output logic [reg_idx_w-1:0] i_uimm5,
	output logic [3:0]           i_funct,
	output alu_src_e             i_alu_src,
	output logic                 i_dm_rd, i_dm_wr, i_reg_we, i_mem_reg, i_x_out,
	output lsu_mode_e            i_lsu_mode
);

	// Decoded fields, IF/ID and ID/EX
	logic                 pres_is_vec, prev_is_vec;
	logic [reg_idx_w-1:0] pres_vs1, pres_vs2, pres_vd, pres_rs1_idx, pres_rs2_idx, pres_uimm5;
	logic [reg_idx_w-1:0] prev_vs1, prev_vs2, prev_vd, prev_rs1_idx, prev_rs2_idx, prev_uimm5;
	logic [reg_idx_w-1:0] rd_vs1, rd_vs2, rd_vd, rd_rs1_idx, rd_rs2_idx, rd_uimm5;
	logic [3:0]           pres_funct, prev_funct, rd_funct;
	alu_src_e             pres_alu_src, prev_alu_src, rd_alu_src;
	lsu_mode_e            pres_lsu_mode, prev_lsu_mode, rd_lsu_mode;
	logic                 pres_dm_rd, pres_dm_wr, pres_reg_we, pres_mem_reg, pres_x_out;
	logic                 prev_dm_rd, prev_dm_wr, prev_reg_we, prev_mem_reg, prev_x_out;
	logic                 rd_dm_rd, rd_dm_wr, rd_reg_we, rd_mem_reg, rd_x_out;
	// Control between the blocks
	logic                 cap_en, cap_sel_prev, buf_clear, disp_en, disp_clear;
	logic [slot_w-1:0]    cap_slot, rd_slot;
	logic [slot_w:0]      cap_count;

	////////////////////////////////////////////////////////////////////////////
	vec_decoder dec_pres (
		.instr   (inst_if_id),    .is_vec  (pres_is_vec),
		.vs1     (pres_vs1),      .vs2     (pres_vs2),      .vd      (pres_vd),
		.rs1_idx (pres_rs1_idx),  .rs2_idx (pres_rs2_idx),  .uimm5   (pres_uimm5),
		.funct   (pres_funct),    .alu_src (pres_alu_src),
		.dm_rd   (pres_dm_rd),    .dm_wr   (pres_dm_wr),    .reg_we  (pres_reg_we),
		.mem_reg (pres_mem_reg),  .x_out   (pres_x_out),    .lsu_mode(pres_lsu_mode)
	);

	vec_decoder dec_prev (
		.instr   (inst_id_ex),    .is_vec  (prev_is_vec),
		.vs1     (prev_vs1),      .vs2     (prev_vs2),      .vd      (prev_vd),
		.rs1_idx (prev_rs1_idx),  .rs2_idx (prev_rs2_idx),  .uimm5   (prev_uimm5),
		.funct   (prev_funct),    .alu_src (prev_alu_src),
		.dm_rd   (prev_dm_rd),    .dm_wr   (prev_dm_wr),    .reg_we  (prev_reg_we),
		.mem_reg (prev_mem_reg),  .x_out   (prev_x_out),    .lsu_mode(prev_lsu_mode)
	);

	// Port names match the wires above
	vec_inst_buffer buffer_i (.*);

	vec_convoy_ctrl ctrl_i (.*);

	vec_dispatch dispatch_i (.*);

endmodule

// File: rtl/vec_pkg.sv
package vec_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Convoy geometry and widths
	localparam int n_slots     = 8;    // Instructions per convoy
	localparam int slot_w      = 3;    // Slot index width
	localparam int reg_idx_w   = 5;    // Register index width
	localparam int xlen        = 32;   // Scalar word width

	// Sequencer thresholds
	localparam int drain_thd   = 10;   // Window cycles before exe_done is accepted
	localparam int release_thd = 3;    // Release steps before the pipeline goes
	localparam int max_release = 4;    // Release counter wraps here

	////////////////////////////////////////////////////////////////////////////
	// Major opcodes of the vector extension
	typedef enum logic [6:0] {
		op_vec_load  = 7'b0000111,
		op_vec_store = 7'b0100111,
		op_vec_arith = 7'b1010111
	} vec_opcode_e;

	// ALU operand B source
	typedef enum logic [1:0] {
		src_vv = 2'b00,   // Vector register
		src_vx = 2'b01,   // Scalar register
		src_vi = 2'b11    // uimm5
	} alu_src_e;

	// Load/store addressing mode
	typedef enum logic [1:0] {
		lsu_unit    = 2'b00,
		lsu_strided = 2'b01,
		lsu_indexed = 2'b11
	} lsu_mode_e;

	// Convoy sequencer
	typedef enum logic [1:0] {
		st_idle,
		st_collect,
		st_dispatch,
		st_release
	} convoy_state_e;

endpackage

// File: include/tb_vec_cases.svh
// Vector word pool, each case drives a run of it in program order
logic [31:0] word_pool [0:11] = '{
	32'h022180D7,   // vadd.vv   v1, v2, v3
	32'h0A42C357,   // vsub.vx   v6, v4, x5
	32'h2674B457,   // vand.vi   v8, v7, 9
	32'h02056587,   // vle32.v   v11, (x10)
	32'h0AC6E707,   // vlse32.v  v14, (x13), x12
	32'h0EF868A7,   // vsoxei32  v17, (x16), v15
	32'h9729AA57,   // vmul.vv   v20, v18, v19
	32'h43502B57,   // vmv.x.s   x22, v21
	32'h037C4CD7,   // vadd.vx   v25, v23, x24
	32'h2BADBE57,   // vor.vi    v28, v26, 27
	32'h03DF5FD7,   // vfadd.vf  v31, v29, f30
	32'h06326287    // vluxei32  v5, (x4), v3
};

localparam int n_cases = 11;

// One column per array, one case per index
// first   first pool word of the convoy
// count   vector words driven before the scalar no-op
// branch  drive step that takes a branch, 0 for none
// stall   cycles of exe_stall after the first dispatch
// expect  dispatches the execution unit should see
int case_first  [0:n_cases-1] = '{0, 1, 2, 3, 4, 5, 5,  0, 2, 1, 3};
int case_count  [0:n_cases-1] = '{1, 2, 3, 4, 5, 6, 7, 10, 6, 5, 3};
int case_branch [0:n_cases-1] = '{0, 0, 0, 0, 0, 0, 0,  0, 0, 3, 0};
int case_stall  [0:n_cases-1] = '{0, 0, 0, 0, 0, 0, 0,  0, 4, 0, 0};
int case_expect [0:n_cases-1] = '{1, 2, 3, 4, 5, 6, 7,  8, 6, 0, 3};

// File: tb/tb_vec_issue.sv
`timescale 1ns/1ps

module tb_vec_issue
	import vec_pkg::*;
();

	localparam int          clk_period = 40;
	localparam logic [31:0] nop_word   = 32'h00000013;   // addi x0, x0, 0
	localparam logic [6:0]  opc_arith  = 7'h57;
	localparam logic [6:0]  opc_load   = 7'h07;
	localparam logic [6:0]  opc_store  = 7'h27;

	// DUT inputs
	logic                 reset, clk;                 // Clock, async reset
	logic                 branch_taken_ex_mem, freeze_vector_ops, exe_stall, exe_done;
	logic [xlen-1:0]      inst_if_id, inst_id_ex, rs1_data, rs2_data;
	// DUT outputs
	logic                 sv_vv, v_stall, freeze, freeze_x, i_clear, i_start;
	logic [1:0]           release_count;
	logic [reg_idx_w-1:0] rs1_sel, rs2_sel, i_vs1, i_vs2, i_vd, i_uimm5;
	logic [slot_w-1:0]    i_id;
	logic [xlen-1:0]      i_rs1, i_rs2;
	logic [3:0]           i_funct;
	alu_src_e             i_alu_src;
	logic                 i_dm_rd, i_dm_wr, i_reg_we, i_mem_reg, i_x_out;
	lsu_mode_e            i_lsu_mode;

	`include "tb_vec_cases.svh"

	localparam int wd_cycles = n_cases * 64 + 16;   // Watchdog budget

	int                   err_count = 0;
	int                   cur_case  = 0;
	int                   disp_seen = 0;     // i_start pulses in this case
	logic                 fx_seen, fz_seen;  // freeze_x / freeze seen in this case
	logic                 mon_on    = 1'b0;
	logic [31:0]          lcg_state = 32'hb37;
	logic [31:0]          rs1_hist, rs2_hist; // Operands of the previous cycle
	logic [reg_idx_w-1:0] sel1_hist, sel2_hist; // Register selects of the previous cycle

	vec_issue_top dut_i (.*);

	always #(clk_period / 2) reset = ~reset;

	////////////////////////////////////////////////////////////////////////////
	// Expected decode, straight from the RVV encoding
	function automatic logic [3:0] funct_of(input logic [31:0] w);
		if (w[6:0] == opc_arith)
			return w[29:26];          // Low nibble of funct6
		return 4'd0;
	endfunction

	function automatic alu_src_e src_of(input logic [31:0] w);
		if (w[6:0] != opc_arith)
			return src_vx;            // Memory ops add rs1
		case (w[14:12])
			3'b011:                 return src_vi;
			3'b100, 3'b101, 3'b110: return src_vx;
			default:                return src_vv;
		endcase
	endfunction

	function automatic lsu_mode_e mode_of(input logic [31:0] w);
		if (w[6:0] == opc_arith)
			return lsu_unit;
		case (w[27:26])               // mop
			2'b00:   return lsu_unit;
			2'b10:   return lsu_strided;
			default: return lsu_indexed;
		endcase
	endfunction

	// OPMVV funct6 010000 (vmv.x.s and kin) returns a scalar
	function automatic logic writes_x(input logic [31:0] w);
		return w[6:0] == opc_arith && w[14:12] == 3'b010 && w[31:26] == 6'b010000;
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_count++;
			$display("FAIL %0t ns %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_src(input string name, input alu_src_e got, input alu_src_e exp);
		if (got !== exp) begin
			err_count++;
			$display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_mode(input string name, input lsu_mode_e got, input lsu_mode_e exp);
		if (got !== exp) begin
			err_count++;
			$display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_field(input string name, input logic [reg_idx_w-1:0] got,
		input logic [reg_idx_w-1:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// One i_start against the word it should carry
	task automatic score_dispatch();
		logic [31:0] w;
		logic        is_ld, is_st;
		if (disp_seen >= case_expect[cur_case]) begin
			err_count++;
			$display("Extra i_start at %0t ns in case %0d", $time, cur_case);
		end else begin
			w     = word_pool[case_first[cur_case] + disp_seen];
			is_ld = (w[6:0] == opc_load);
			is_st = (w[6:0] == opc_store);
			check_field("i_id", 5'(i_id), 5'(disp_seen));
			check_field("i_vd", i_vd, w[11:7]);
			check_field("i_vs1", i_vs1, w[19:15]);
			check_field("i_vs2", i_vs2, w[24:20]);
			check_field("i_uimm5", i_uimm5, w[19:15]);
			check_field("i_funct", 5'(i_funct), 5'(funct_of(w)));
			check_src("i_alu_src", i_alu_src, src_of(w));
			check_mode("i_lsu_mode", i_lsu_mode, mode_of(w));
			check_flag("i_dm_rd", i_dm_rd, is_ld);
			check_flag("i_dm_wr", i_dm_wr, is_st);
			check_flag("i_mem_reg", i_mem_reg, is_ld);     // Loads write back from memory
			check_flag("i_x_out", i_x_out, writes_x(w));
			check_flag("i_reg_we", i_reg_we, is_ld || (!is_st && !writes_x(w)));
			check_field("rs1_sel", sel1_hist, w[19:15]);   // Selects of the issue cycle
			check_field("rs2_sel", sel2_hist, w[24:20]);
			check_word("i_rs1", i_rs1, rs1_hist);   // Operands of the issue cycle
			check_word("i_rs2", i_rs2, rs2_hist);
		end
		disp_seen++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Pipeline model and monitor
	always @(posedge reset)
		inst_id_ex <= inst_if_id;   // ID/EX trails IF/ID by one stage

	always @(posedge reset) begin
		rs1_data <= lcg_next();
		rs2_data <= lcg_next();
	end

	always @(negedge reset) begin   // Mid-cycle, all outputs settled
		if (mon_on) begin
			if (freeze_x)
				fx_seen = 1'b1;
			if (freeze)
				fz_seen = 1'b1;
			if (i_start)
				score_dispatch();
		end
		rs1_hist  = rs1_data;
		rs2_hist  = rs2_data;
		sel1_hist = rs1_sel;
		sel2_hist = rs2_sel;
	end

	// One convoy from the table
	task automatic run_case(input int c);
		repeat (3) @(posedge reset);              // Scalar gap between convoys
		cur_case  = c;
		disp_seen = 0;
		fx_seen   = 1'b0;
		fz_seen   = 1'b0;
		for (int s = 0; s < case_count[c]; s++) begin
			@(posedge reset);
			if (case_branch[c] != 0 && s == case_branch[c]) begin
				branch_taken_ex_mem <= 1'b1;
				inst_if_id          <= nop_word;  // Branch flushes the fetch stage
				break;
			end
			inst_if_id <= word_pool[case_first[c] + s];
		end
		@(posedge reset);
		inst_if_id          <= nop_word;
		branch_taken_ex_mem <= 1'b0;

		if (case_branch[c] != 0) begin
			repeat (3) @(posedge reset);
			@(negedge reset);
			check_flag("v_stall", v_stall, 1'b0);  // Convoy cancelled
			check_flag("freeze", freeze, 1'b0);
			check_flag("freeze_x", freeze_x, 1'b0);
		end else begin
			if (case_stall[c] > 0) begin
				while (disp_seen == 0)
					@(posedge reset);
				exe_stall <= 1'b1;
				repeat (case_stall[c]) @(posedge reset);
				exe_stall <= 1'b0;
			end
			while (disp_seen < case_expect[c])
				@(posedge reset);
			repeat (drain_thd) @(posedge reset);
			@(negedge reset);
			check_flag("i_clear", i_clear, 1'b0);
			@(posedge reset);
			exe_done <= 1'b1;
			@(negedge reset);
			while (!i_clear)
				@(negedge reset);
			check_flag("v_stall", v_stall, 1'b1);  // Release still pending
			check_flag("sv_vv", sv_vv, 1'b1);      // Entered behind a scalar no-op
			@(posedge reset);
			exe_done <= 1'b0;
			@(negedge reset);
			while (v_stall)
				@(negedge reset);
			check_flag("freeze", freeze, 1'b0);
			check_flag("freeze_x", freeze_x, 1'b0);
			check_field("release_count", 5'(release_count), 5'd0);
			check_flag("freeze seen", fz_seen, 1'b1);
			if (case_count[c] < n_slots)
				check_flag("freeze_x seen", fx_seen, 1'b1);   // Scalar word broke it
		end
		check_field("dispatch count", 5'(disp_seen), 5'(case_expect[c]));
	endtask

	////////////////////////////////////////////////////////////////////////////
	initial begin
		reset               = 1'b0;
		clk                 = 1'b1;
		branch_taken_ex_mem = 1'b0;
		freeze_vector_ops   = 1'b0;
		exe_stall           = 1'b0;
		exe_done            = 1'b0;
		inst_if_id          = nop_word;
		inst_id_ex          = nop_word;
		rs1_data            = '0;
		rs2_data            = '0;
		repeat (8) @(posedge reset);
		clk <= 1'b0;
		@(negedge reset);
		// Idle values out of reset
		check_flag("v_stall", v_stall, 1'b0);
		check_flag("freeze", freeze, 1'b0);
		check_flag("freeze_x", freeze_x, 1'b0);
		check_flag("sv_vv", sv_vv, 1'b0);
		check_flag("i_start", i_start, 1'b0);
		check_flag("i_clear", i_clear, 1'b1);
		check_field("release_count", 5'(release_count), 5'd0);
		mon_on = 1'b1;
		for (int c = 0; c < n_cases; c++)
			run_case(c);
		repeat (4) @(posedge reset);
		$display("Errors: %0d", err_count);
		if (err_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(wd_cycles * clk_period);
		$display("Watchdog expired before the last case finished");
		$display("test failed");
		$finish;
	end

endmodule
